/* Bender.yml */
package:
  name: ptp_clock_cdc

sources:
  - include_dirs:
      - source
    files:
      - source/ptp_cdc_pkg.sv
      - source/ptp_cdc_if.sv
      - source/ptp_ts_capture.sv
      - source/ptp_ts_sync.sv
      - source/ptp_time_compare.sv
      - source/ptp_servo.sv
      - source/ptp_local_clock.sv
      - source/ptp_clock_cdc.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/ptp_clock_cdc_assertions.sv
      - testbench/ptp_clock_cdc_tb.sv

/* source/ptp_cdc_config.svh */
// Build constants for the PTP clock CDC, included by the package, the RTL and the testbench
`ifndef PTP_CDC_CONFIG_SVH
`define PTP_CDC_CONFIG_SVH

// capture every 2^PTP_LOG_RATE input cycles
`define PTP_LOG_RATE 3

`define PTP_FNS_W 16
`define PTP_CMP_FNS_W 4

// integer ns bits of the increment, enough for a 20 ns period
`define PTP_PERIOD_NS_W 5

`define PTP_NS_PER_S 1000000000

// 20 ns in 1/65536 ns
`define PTP_NOM_PERIOD (20 * 65536)

`define PTP_MISMATCH_LIMIT 16

// differences at or above 2^9 ns count as coarse mismatches
`define PTP_COARSE_BIT 9

`endif

/* source/ptp_cdc_if.sv */
// Interfaces for the captured timestamp crossing and the synchronised sample stream
`timescale 1ns/100ps

// fields are stable in input_clk registers whenever toggle changes
interface ts_capture_if import ptp_cdc_pkg::*; ();
    ptp_sec_t    sec;
    ptp_cmp_ns_t ns;
    logic        step;
    logic        toggle;

    modport source (output sec, ns, step, toggle);
    modport sink (input sec, ns, step, toggle);
endinterface

// output_clk domain, valid is a single-cycle strobe
interface ts_sample_if import ptp_cdc_pkg::*; ();
    ptp_sec_t    sec;
    ptp_cmp_ns_t ns;
    logic        step;
    logic        valid;

    modport source (output sec, ns, step, valid);
    modport sink (input sec, ns, step, valid);
endinterface

/* source/ptp_cdc_pkg.sv */
// Shared vector types of the PTP clock CDC, imported by the RTL modules and interfaces
package ptp_cdc_pkg;

`include "ptp_cdc_config.svh"

typedef logic [47:0] ptp_sec_t;

// 30 bits of ns plus the 16-bit fraction
typedef logic [30+`PTP_FNS_W-1:0] ptp_ns_t;

// ns with a reduced fraction, as sent across the crossing
typedef logic [30+`PTP_CMP_FNS_W-1:0] ptp_cmp_ns_t;

// seconds, two zero bits, ns with fraction
typedef logic [95:0] ptp_ts96_t;

typedef logic [`PTP_PERIOD_NS_W+`PTP_FNS_W-1:0] ptp_period_t;

// signed, in 1/16 ns
typedef logic [`PTP_COARSE_BIT+`PTP_CMP_FNS_W-1:0] ptp_diff_t;

typedef logic [`PTP_PERIOD_NS_W+`PTP_FNS_W-1:0] ptp_err_int_t;

typedef logic [7:0] ptp_lock_cnt_t;

typedef logic [$clog2(`PTP_MISMATCH_LIMIT)-1:0] ptp_mismatch_cnt_t;

endpackage

/* source/ptp_clock_cdc.sv */
// Top level of the PTP clock CDC, recreating the input-domain time of day in output_clk
`timescale 1ns/100ps

module ptp_clock_cdc import ptp_cdc_pkg::*; (
    input  logic      input_clk,
    input  logic      input_rst,
    input  logic      output_clk,
    input  logic      output_rst,
    input  ptp_ts96_t input_ts,
    input  logic      input_ts_step,
    output ptp_ts96_t output_ts,
    output logic      output_ts_step,
    output logic      output_pps,
    output logic      output_pps_str,
    output logic      locked
);

ts_capture_if cap_if ();
ts_sample_if smp_if ();

logic load;
ptp_sec_t load_sec;
ptp_ns_t load_ns;
ptp_sec_t cur_sec;
ptp_ns_t cur_ns;
ptp_diff_t diff;
logic diff_valid;
ptp_period_t period;

ptp_ts_capture i_ptp_ts_capture (
    .input_clk     (input_clk),
    .input_rst     (input_rst),
    .input_ts      (input_ts),
    .input_ts_step (input_ts_step),
    .cap           (cap_if.source)
);

ptp_ts_sync i_ptp_ts_sync (
    .output_clk (output_clk),
    .output_rst (output_rst),
    .cap        (cap_if.sink),
    .smp        (smp_if.source)
);

ptp_time_compare i_ptp_time_compare (
    .output_clk (output_clk),
    .output_rst (output_rst),
    .smp        (smp_if.sink),
    .cur_sec    (cur_sec),
    .cur_ns     (cur_ns),
    .load       (load),
    .load_sec   (load_sec),
    .load_ns    (load_ns),
    .diff       (diff),
    .diff_valid (diff_valid)
);

ptp_servo i_ptp_servo (
    .output_clk (output_clk),
    .output_rst (output_rst),
    .diff       (diff),
    .diff_valid (diff_valid),
    .period     (period),
    .locked     (locked)
);

ptp_local_clock i_ptp_local_clock (
    .output_clk     (output_clk),
    .output_rst     (output_rst),
    .period         (period),
    .load           (load),
    .load_sec       (load_sec),
    .load_ns        (load_ns),
    .cur_sec        (cur_sec),
    .cur_ns         (cur_ns),
    .output_ts      (output_ts),
    .output_ts_step (output_ts_step),
    .output_pps     (output_pps),
    .output_pps_str (output_pps_str)
);

endmodule

/* source/ptp_local_clock.sv */
// Local time-of-day counter with load, one-second rollover, PPS and 96-bit output
`timescale 1ns/100ps
`include "ptp_cdc_config.svh"

module ptp_local_clock import ptp_cdc_pkg::*; (
    input  logic        output_clk,
    input  logic        output_rst,
    input  ptp_period_t period,
    input  logic        load,
    input  ptp_sec_t    load_sec,
    input  ptp_ns_t     load_ns,
    output ptp_sec_t    cur_sec,
    output ptp_ns_t     cur_ns,
    output ptp_ts96_t   output_ts,
    output logic        output_ts_step,
    output logic        output_pps,
    output logic        output_pps_str
);

localparam int NS_W = $bits(ptp_ns_t);
localparam ptp_ns_t ONE_SECOND = ptp_ns_t'(`PTP_NS_PER_S) << `PTP_FNS_W;

ptp_sec_t sec;
ptp_ns_t ns;
ptp_ns_t ns_inc;
// ns_inc minus one second, top bit is the borrow
logic [NS_W:0] ns_ovf;
ptp_period_t period_d;
ptp_ns_t period_ovf;

// period_ovf always matches period_d
always_ff @(posedge output_clk) begin
    period_d <= period;
    period_ovf <= ONE_SECOND - period;
end

always_ff @(posedge output_clk) begin
    ns <= ns_inc;
    ns_inc <= ns_inc + period_d;
    ns_ovf <= {1'b0, ns_inc} - {1'b0, period_ovf};

    output_ts_step <= 1'b0;
    output_pps <= 1'b0;
    if (ns[`PTP_FNS_W+29]) begin
        output_pps_str <= 1'b0;
    end

    if (load) begin
        sec <= load_sec;
        ns <= load_ns;
        ns_inc <= load_ns + period_d;
        ns_ovf <= {1'b0, load_ns} - {1'b0, period_ovf};
        output_ts_step <= 1'b1;
    end else if (!ns_ovf[NS_W]) begin
        // no borrow, so ns_inc reached one second
        sec <= sec + 1'b1;
        ns <= ns_ovf[NS_W-1:0];
        ns_inc <= ns_ovf[NS_W-1:0] + period_d;
        ns_ovf <= {1'b0, ns_ovf[NS_W-1:0]} - {1'b0, period_ovf};
        output_pps <= 1'b1;
        output_pps_str <= 1'b1;
    end

    if (output_rst) begin
        sec <= '0;
        ns <= '0;
        ns_inc <= '0;
        ns_ovf <= '1;
        output_ts_step <= 1'b0;
        output_pps <= 1'b0;
        output_pps_str <= 1'b0;
    end
end

assign cur_sec = sec;
assign cur_ns = ns;
assign output_ts = {sec, 2'b00, ns};

endmodule

/* source/ptp_servo.sv */
// PI servo that trims the local clock increment from the measured time error
`timescale 1ns/100ps
`include "ptp_cdc_config.svh"

module ptp_servo import ptp_cdc_pkg::*; (
    input  logic        output_clk,
    input  logic        output_rst,
    input  ptp_diff_t   diff,
    input  logic        diff_valid,
    output ptp_period_t period,
    output logic        locked
);

localparam int W = $bits(ptp_err_int_t);
localparam int DW = $bits(ptp_diff_t);

ptp_err_int_t err_int;
ptp_lock_cnt_t lock_cnt;
logic high_gain;
logic signed [W+1:0] int_sum;
logic signed [W+1:0] per_sum;

// top bit flags a result below zero, next bit a carry past all ones
function automatic ptp_err_int_t saturate(input logic [W+1:0] sum);
    if (sum[W+1]) begin
        return '0;
    end
    if (sum[W]) begin
        return '1;
    end
    return sum[W-1:0];
endfunction

// error outside roughly +/-16 ns
assign high_gain = (|diff[DW-1 -: 5]) && !(&diff[DW-1 -: 5]);

always_comb begin
    if (high_gain) begin
        int_sum = $signed({2'b00, err_int}) + (W+2)'($signed(diff) * 4);
        per_sum = $signed({2'b00, err_int}) + (W+2)'($signed(diff) * 64);
    end else begin
        int_sum = $signed({2'b00, err_int}) + (W+2)'($signed(diff) / 16);
        per_sum = $signed({2'b00, err_int}) + (W+2)'($signed(diff) * 4);
    end
end

always_ff @(posedge output_clk) begin
    if (diff_valid) begin
        err_int <= saturate(int_sum);
        period <= saturate(per_sum);

        if (high_gain) begin
            if (lock_cnt != '0) begin
                lock_cnt <= lock_cnt - 1'b1;
            end else begin
                locked <= 1'b0;
            end
        end else begin
            if (&lock_cnt) begin
                locked <= 1'b1;
            end else begin
                lock_cnt <= lock_cnt + 1'b1;
            end
        end
    end

    // start at the nominal rate so the clock runs before any sample
    if (output_rst) begin
        err_int <= ptp_err_int_t'(`PTP_NOM_PERIOD);
        period <= ptp_period_t'(`PTP_NOM_PERIOD);
        lock_cnt <= '0;
        locked <= 1'b0;
    end
end

endmodule

/* source/ptp_time_compare.sv */
// Compares each synchronised sample with the local time and issues a load or a time error
`timescale 1ns/100ps
`include "ptp_cdc_config.svh"

module ptp_time_compare import ptp_cdc_pkg::*; (
    input  logic        output_clk,
    input  logic        output_rst,
    ts_sample_if.sink   smp,
    input  ptp_sec_t    cur_sec,
    input  ptp_ns_t     cur_ns,
    output logic        load,
    output ptp_sec_t    load_sec,
    output ptp_ns_t     load_ns,
    output ptp_diff_t   diff,
    output logic        diff_valid
);

localparam int CMP_W = $bits(ptp_cmp_ns_t);
localparam int COARSE_LSB = `PTP_COARSE_BIT + `PTP_CMP_FNS_W;

ptp_cmp_ns_t local_ns;
ptp_cmp_ns_t ns_delta;
logic mismatch;
logic reload_pending;
ptp_mismatch_cnt_t mismatch_cnt;

// local time trimmed to the same fraction as the sample
assign local_ns = cur_ns[$bits(ptp_ns_t)-1 -: CMP_W];
assign ns_delta = smp.ns - local_ns;
assign mismatch = (smp.sec != cur_sec) ||
                  (smp.ns[CMP_W-1:COARSE_LSB] != local_ns[CMP_W-1:COARSE_LSB]);

always_ff @(posedge output_clk) begin
    load <= 1'b0;
    diff_valid <= 1'b0;

    if (smp.valid) begin
        if (smp.step || reload_pending) begin
            load <= 1'b1;
            load_sec <= smp.sec;
            load_ns <= {smp.ns, {(`PTP_FNS_W-`PTP_CMP_FNS_W){1'b0}}};
            reload_pending <= 1'b0;
            mismatch_cnt <= '0;
        end else begin
            diff_valid <= 1'b1;
            diff <= ns_delta[$bits(ptp_diff_t)-1:0];

            // too many coarse misses in a row, reload on the next sample
            if (mismatch) begin
                if (mismatch_cnt == ptp_mismatch_cnt_t'(`PTP_MISMATCH_LIMIT - 1)) begin
                    reload_pending <= 1'b1;
                    mismatch_cnt <= '0;
                end else begin
                    mismatch_cnt <= mismatch_cnt + 1'b1;
                end
            end else begin
                mismatch_cnt <= '0;
            end
        end
    end

    if (output_rst) begin
        load <= 1'b0;
        diff_valid <= 1'b0;
        reload_pending <= 1'b0;
        mismatch_cnt <= '0;
    end
end

endmodule

/* source/ptp_ts_capture.sv */
// Input-domain stage that periodically captures the source timestamp for the clock crossing
`timescale 1ns/100ps
`include "ptp_cdc_config.svh"

module ptp_ts_capture import ptp_cdc_pkg::*; (
    input  logic         input_clk,
    input  logic         input_rst,
    input  ptp_ts96_t    input_ts,
    input  logic         input_ts_step,
    ts_capture_if.source cap
);

logic [`PTP_LOG_RATE-1:0] phase;
logic phase_wrap;
logic step_pending;

always_ff @(posedge input_clk) begin
    {phase_wrap, phase} <= phase + 1'b1;

    // remember a step until the next capture carries it
    step_pending <= step_pending | input_ts_step;

    if (phase_wrap) begin
        cap.sec <= input_ts[95:48];
        cap.ns <= input_ts[45 -: $bits(ptp_cmp_ns_t)];
        cap.step <= step_pending | input_ts_step;
        step_pending <= 1'b0;
        cap.toggle <= ~cap.toggle;
    end

    if (input_rst) begin
        phase <= '0;
        phase_wrap <= 1'b0;
        step_pending <= 1'b0;
        cap.toggle <= 1'b0;
    end
end

endmodule

/* source/ptp_ts_sync.sv */
// Output-domain receiver that synchronises the capture toggle and presents each sample
`timescale 1ns/100ps

module ptp_ts_sync (
    input  logic         output_clk,
    input  logic         output_rst,
    ts_capture_if.sink   cap,
    ts_sample_if.source  smp
);

// three flops, the edge is seen between the last two
logic [2:0] toggle_sync;

always_ff @(posedge output_clk) begin
    toggle_sync <= {toggle_sync[1:0], cap.toggle};

    smp.valid <= 1'b0;
    if (toggle_sync[1] ^ toggle_sync[2]) begin
        // fields have been stable since before the toggle flipped
        smp.sec <= cap.sec;
        smp.ns <= cap.ns;
        smp.step <= cap.step;
        smp.valid <= 1'b1;
    end

    if (output_rst) begin
        toggle_sync <= '0;
        smp.valid <= 1'b0;
    end
end

endmodule

/* testbench/ptp_clock_cdc_assertions.sv */
// Concurrent checks on the PTP clock CDC top-level outputs that bind into ptp_clock_cdc
`timescale 1ns/100ps
`include "ptp_cdc_config.svh"

module ptp_clock_cdc_assertions import ptp_cdc_pkg::*; (
    input logic      output_clk,
    input logic      output_rst,
    input ptp_ts96_t output_ts,
    input logic      output_ts_step,
    input logic      output_pps,
    input logic      output_pps_str,
    input logic      locked
);

// failures seen so far
int fail_count = 0;

pps_has_str: assert property (@(posedge output_clk) disable iff (output_rst)
    output_pps |-> output_pps_str)
    else begin
        fail_count++;
        $error("output_pps high without output_pps_str");
    end

step_one_cycle: assert property (@(posedge output_clk) disable iff (output_rst)
    output_ts_step |=> !output_ts_step)
    else begin
        fail_count++;
        $error("output_ts_step longer than one cycle");
    end

pps_one_cycle: assert property (@(posedge output_clk) disable iff (output_rst)
    output_pps |=> !output_pps)
    else begin
        fail_count++;
        $error("output_pps longer than one cycle");
    end

ns_in_range: assert property (@(posedge output_clk) disable iff (output_rst)
    output_ts[45:16] < `PTP_NS_PER_S)
    else begin
        fail_count++;
        $error("nanoseconds field reached one second");
    end

// first cycle out of reset
quiet_after_reset: assert property (@(posedge output_clk)
    $fell(output_rst) |=> !(output_ts_step || output_pps || output_pps_str || locked))
    else begin
        fail_count++;
        $error("strobes or locked high right after reset");
    end

endmodule

bind ptp_clock_cdc ptp_clock_cdc_assertions i_ptp_clock_cdc_assertions (.*);

/* testbench/ptp_clock_cdc_tb.sv */
// Directed testbench that runs the PTP clock CDC as top module ptp_clock_cdc_tb from vlog.f
`timescale 1ns/100ps
`include "ptp_cdc_config.svh"

module ptp_clock_cdc_tb import ptp_cdc_pkg::*; ();

logic input_clk;
logic input_rst;
logic output_clk;
logic output_rst;
ptp_ts96_t input_ts;
logic input_ts_step;
ptp_ts96_t output_ts;
logic output_ts_step;
logic output_pps;
logic output_pps_str;
logic locked;

// source time model in whole ns
ptp_sec_t src_sec;
logic [29:0] src_ns;
logic set_req;
ptp_sec_t set_sec;
logic [29:0] set_ns;
logic set_step;

int value_errors = 0;
int other_errors = 0;

ptp_clock_cdc i_ptp_clock_cdc (.*);

initial begin
    output_clk = 1'b0;
    forever #10 output_clk = ~output_clk;
end

initial begin
    input_clk = 1'b0;
    #7;
    forever #10 input_clk = ~input_clk;
end

// advances 20 ns per input cycle unless a new time is requested
initial begin
    src_sec = '0;
    src_ns = '0;
    set_req = 1'b0;
    input_ts_step = 1'b0;
    input_ts = '0;
    forever begin
        @(negedge input_clk);
        input_ts_step = 1'b0;
        if (set_req) begin
            src_sec = set_sec;
            src_ns = set_ns;
            input_ts_step = set_step;
            set_req = 1'b0;
        end else if (src_ns + 20 >= `PTP_NS_PER_S) begin
            src_sec = src_sec + 1'b1;
            src_ns = src_ns + 20 - `PTP_NS_PER_S;
        end else begin
            src_ns = src_ns + 20;
        end
        input_ts = {src_sec, 2'b00, src_ns, 16'h0000};
    end
end

task automatic check_value(input string test, input logic [95:0] expected,
                           input logic [95:0] actual);
    if (actual !== expected) begin
        value_errors++;
        $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
    end
endtask

task automatic report_failure(input string msg);
    other_errors++;
    $display("failure at %0t ns: %s", $time, msg);
endtask

// model time minus output time in ns
function automatic longint model_lag();
    longint sec_diff;
    longint ns_diff;
    sec_diff = longint'(src_sec) - longint'(output_ts[95:48]);
    ns_diff = longint'(src_ns) - longint'(output_ts[45:16]);
    return sec_diff * `PTP_NS_PER_S + ns_diff;
endfunction

task automatic set_source(input ptp_sec_t sec, input logic [29:0] ns, input logic step);
    int n;
    set_sec = sec;
    set_ns = ns;
    set_step = step;
    set_req = 1'b1;
    for (n = 0; n < 10 && set_req; n++) begin
        @(negedge output_clk);
    end
    if (set_req) begin
        report_failure("source model did not take the new time");
    end
endtask

task automatic wait_for_output(input string name, input int limit, output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < limit && !seen; n++) begin
        @(negedge output_clk);
        case (name)
            "output_ts_step": seen = output_ts_step;
            "output_pps": seen = output_pps;
            default: seen = locked;
        endcase
    end
    if (!seen) begin
        report_failure($sformatf("%s did not rise within %0d cycles", name, limit));
    end
endtask

task automatic check_outputs_idle(input string test);
    check_value(test, '0, output_ts);
    check_value(test, 1'b0, output_ts_step);
    check_value(test, 1'b0, output_pps);
    check_value(test, 1'b0, output_pps_str);
    check_value(test, 1'b0, locked);
endtask

task automatic test_reset();
    repeat (3) begin
        @(negedge output_clk);
        check_outputs_idle("reset");
    end
    output_rst = 1'b0;
    input_rst = 1'b0;
    @(negedge output_clk);
    check_outputs_idle("first cycle after reset");
endtask

task automatic test_step();
    ptp_sec_t s;
    bit seen;
    longint lag;
    s = ptp_sec_t'($urandom());
    set_source(s, 30'd500_000_000, 1'b1);
    wait_for_output("output_ts_step", 40, seen);
    if (seen) begin
        lag = model_lag();
        check_value("step load seconds", s, output_ts[95:48]);
        if (lag < 0 || lag > 2000) begin
            report_failure($sformatf("step load: output is %0d ns behind the model", lag));
        end
    end
endtask

task automatic test_rollover();
    ptp_sec_t s;
    bit seen;
    int n;
    s = ptp_sec_t'($urandom());
    set_source(s, 30'd999_990_000, 1'b1);
    wait_for_output("output_ts_step", 40, seen);
    seen = 1'b0;
    for (n = 0; n < 1000 && !seen; n++) begin
        @(negedge output_clk);
        seen = output_pps;
    end
    if (!seen) begin
        report_failure("rollover: output_pps did not pulse within 1000 cycles");
    end else begin
        check_value("rollover pps_str", 1'b1, output_pps_str);
        check_value("rollover seconds", ptp_sec_t'(s + 1'b1), output_ts[95:48]);
        if (output_ts[45:16] >= 1000) begin
            report_failure($sformatf("rollover: ns at pps is %0d", output_ts[45:16]));
        end
    end
endtask

task automatic test_lock();
    bit seen;
    bit drifted;
    int n;
    longint lag;
    drifted = 1'b0;
    wait_for_output("locked", 20000, seen);
    for (n = 0; n < 200 && seen && !drifted; n++) begin
        @(negedge output_clk);
        lag = model_lag();
        if (lag < -512 || lag > 512) begin
            drifted = 1'b1;
            report_failure($sformatf("lock: output is %0d ns off the model", lag));
        end
    end
endtask

task automatic test_mismatch_reload();
    ptp_sec_t sec;
    logic [31:0] ns;
    bit seen;
    longint lag;
    sec = src_sec;
    ns = src_ns + 5000;
    if (ns >= `PTP_NS_PER_S) begin
        sec = sec + 1'b1;
        ns = ns - `PTP_NS_PER_S;
    end
    // jump without a step so only the compare stage can catch it
    set_source(sec, ns[29:0], 1'b0);
    wait_for_output("output_ts_step", 400, seen);
    if (seen) begin
        lag = model_lag();
        if (lag < -2000 || lag > 2000) begin
            report_failure($sformatf("reload: output is %0d ns off the model", lag));
        end
        repeat (16) @(negedge output_clk);
        lag = model_lag();
        if (lag < -2000 || lag > 2000) begin
            report_failure($sformatf("after reload: output is %0d ns off the model", lag));
        end
    end
endtask

initial begin
    output_rst = 1'b1;
    input_rst = 1'b1;
    void'($urandom(32'h40ab_1085));
    test_reset();
    test_step();
    test_rollover();
    test_lock();
    test_mismatch_reload();
    $display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
             i_ptp_clock_cdc.i_ptp_clock_cdc_assertions.fail_count);
    if (value_errors + other_errors +
        i_ptp_clock_cdc.i_ptp_clock_cdc_assertions.fail_count == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

/* vlog.f */
+incdir+source
source/ptp_cdc_pkg.sv
source/ptp_cdc_if.sv
source/ptp_ts_capture.sv
source/ptp_ts_sync.sv
source/ptp_time_compare.sv
source/ptp_servo.sv
source/ptp_local_clock.sv
source/ptp_clock_cdc.sv
testbench/ptp_clock_cdc_assertions.sv
testbench/ptp_clock_cdc_tb.sv
